// File: verilog/board_bus_params.svh
/* address spaces, board register indices, status fields,
   firmware version, hub depth and watchdog prescale */
`ifndef BOARD_BUS_PARAMS_SVH
`define BOARD_BUS_PARAMS_SVH

// ----------------------------------------------------------
// address spaces, reg_addr[15:12]
// ----------------------------------------------------------
`define ADDR_MAIN           4'd0    // board registers and channel data
`define ADDR_HUB            4'd1    // hub quadlet memory

// ----------------------------------------------------------
// main space, channel 0 register index, reg_addr[3:0]
// ----------------------------------------------------------
`define REG_STATUS          4'd0    // board status and control
`define REG_WDOG            4'd3    // watchdog period
`define REG_VERSION         4'd4    // firmware version
`define REG_IPADDR          4'd11   // IP address

// status register fields
`define STATUS_LED_BIT      8       // LED control bit
`define STATUS_WDOG_CLR_BIT 9       // write 1 to clear the timeout flag

`define FW_VERSION          32'h0000_0008   // returned by REG_VERSION

`define HUB_QUADS           16      // hub memory depth in quadlets
`define WDOG_TICK           4       // clocks per watchdog period unit

`endif

// File: verilog/board_bus_pkg.sv
/* register bus types: address, quadlet, block-write address,
   real-time address, sample address and sample channel */
package board_bus_pkg;

    // ----------------------------------------------------------
    // shared bus
    // ----------------------------------------------------------

    // [15:12] space, [7:4] channel, [3:0] register index
    typedef logic [15:0] reg_addr_t;

    typedef logic [31:0] reg_data_t;    // one quadlet

    // ----------------------------------------------------------
    // master side
    // ----------------------------------------------------------

    // real-time block writer, zero-extended onto the bus
    typedef logic [7:0]  bw_addr_t;

    typedef logic [3:0]  rt_addr_t;     // real-time write port address

    // ----------------------------------------------------------
    // data sampler
    // ----------------------------------------------------------
    typedef logic [5:0]  sample_addr_t; // sample buffer index
    typedef logic [3:0]  chan_t;        // channel being sampled

endpackage

// File: verilog/write_bus_arbiter.sv
/* fixed-priority write bus selection (bw, eth, fw), real-time
   write port selection and sample request merging */
`timescale 1ns/1ps

module write_bus_arbiter (
    // real-time block writer, highest priority
    input  logic                        bw_write_en,
    input  logic                        bw_reg_wen,
    input  logic                        bw_blk_wen,
    input  logic                        bw_blk_wstart,
    input  board_bus_pkg::bw_addr_t     bw_reg_waddr,
    input  board_bus_pkg::reg_data_t    bw_reg_wdata,
    // Ethernet side
    input  logic                        eth_write_en,
    input  logic                        eth_reg_wen,
    input  logic                        eth_blk_wen,
    input  logic                        eth_blk_wstart,
    input  board_bus_pkg::reg_addr_t    eth_reg_waddr,
    input  board_bus_pkg::reg_data_t    eth_reg_wdata,
    // FireWire side, default owner
    input  logic                        fw_reg_wen,
    input  logic                        fw_blk_wen,
    input  logic                        fw_blk_wstart,
    input  board_bus_pkg::reg_addr_t    fw_reg_waddr,
    input  board_bus_pkg::reg_data_t    fw_reg_wdata,
    // real-time write requests
    input  logic                        eth_rt_wen,
    input  logic                        fw_rt_wen,
    input  board_bus_pkg::rt_addr_t     eth_rt_waddr,
    input  board_bus_pkg::rt_addr_t     fw_rt_waddr,
    input  board_bus_pkg::reg_data_t    eth_rt_wdata,
    input  board_bus_pkg::reg_data_t    fw_rt_wdata,
    // sampling requests
    input  logic                        eth_sample_start,
    input  logic                        fw_sample_start,
    input  logic                        sample_busy,
    input  logic                        eth_sample_read,
    input  logic                        fw_sample_read,
    input  board_bus_pkg::sample_addr_t eth_sample_raddr,
    input  board_bus_pkg::sample_addr_t fw_sample_raddr,
    // shared write bus
    output logic                        reg_wen,
    output logic                        blk_wen,
    output logic                        blk_wstart,
    output board_bus_pkg::reg_addr_t    reg_waddr,
    output board_bus_pkg::reg_data_t    reg_wdata,
    // real-time port
    output logic                        rt_wen,
    output board_bus_pkg::rt_addr_t     rt_waddr,
    output board_bus_pkg::reg_data_t    rt_wdata,
    // sampler
    output logic                        sample_start,
    output logic                        sample_read,
    output board_bus_pkg::sample_addr_t sample_raddr
);
    import board_bus_pkg::*;

    // ----------------------------------------------------------
    // write bus owner
    // ----------------------------------------------------------
    always_comb begin
        if (bw_write_en) begin
            reg_wen    = bw_reg_wen;
            blk_wen    = bw_blk_wen;
            blk_wstart = bw_blk_wstart;
            reg_waddr  = reg_addr_t'(bw_reg_waddr);    // upper byte zero
            reg_wdata  = bw_reg_wdata;
        end else if (eth_write_en) begin
            reg_wen    = eth_reg_wen;
            blk_wen    = eth_blk_wen;
            blk_wstart = eth_blk_wstart;
            reg_waddr  = eth_reg_waddr;
            reg_wdata  = eth_reg_wdata;
        end else begin                                  // fw when nobody else claims
            reg_wen    = fw_reg_wen;
            blk_wen    = fw_blk_wen;
            blk_wstart = fw_blk_wstart;
            reg_waddr  = fw_reg_waddr;
            reg_wdata  = fw_reg_wdata;
        end
    end

    // real-time port, eth wins only while it strobes
    assign rt_wen   = eth_rt_wen ? 1'b1 : fw_rt_wen;
    assign rt_waddr = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign rt_wdata = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;

    // ----------------------------------------------------------
    // sampler sharing
    // ----------------------------------------------------------
    assign sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy; // no restart mid-run
    assign sample_read  = eth_sample_read | fw_sample_read;
    assign sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;

endmodule

// File: verilog/read_data_router.sv
/* read address selection between sampler, eth and fw, and
   registered read data steering by address space */
`timescale 1ns/1ps
`include "board_bus_params.svh"

module read_data_router (
    input  logic                     sysclk,
    input  logic                     reset,
    input  logic                     sample_busy,     // sampler owns the read address
    input  logic                     eth_read_en,     // eth owns the read address
    input  board_bus_pkg::chan_t     sample_chan,
    input  board_bus_pkg::reg_addr_t eth_reg_raddr,
    input  board_bus_pkg::reg_addr_t fw_reg_raddr,
    input  board_bus_pkg::reg_data_t hub_rdata,
    input  board_bus_pkg::reg_data_t board_rdata,
    input  board_bus_pkg::reg_data_t reg_rdata_ext,
    output board_bus_pkg::reg_addr_t reg_raddr,
    output board_bus_pkg::reg_data_t reg_rdata
);
    import board_bus_pkg::*;

    reg_data_t rdata_sel;       // quadlet for the current address
    logic      is_hub;          // hub space
    logic      is_main_chan0;   // board registers

    // ----------------------------------------------------------
    // read address owner
    // ----------------------------------------------------------
    always_comb begin
        if (sample_busy)
            reg_raddr = {`ADDR_MAIN, 4'd0, sample_chan, 4'd0};   // channel base, index 0
        else if (eth_read_en)
            reg_raddr = eth_reg_raddr;
        else
            reg_raddr = fw_reg_raddr;
    end

    // space decode
    assign is_hub        = (reg_raddr[15:12] == `ADDR_HUB);
    assign is_main_chan0 = (reg_raddr[15:12] == `ADDR_MAIN) && (reg_raddr[7:4] == 4'd0);

    always_comb begin
        if (is_hub)
            rdata_sel = hub_rdata;
        else if (is_main_chan0)
            rdata_sel = board_rdata;
        else
            rdata_sel = reg_rdata_ext;  // channel data and all other spaces
    end

    // ----------------------------------------------------------
    // one-clock read latency
    // ----------------------------------------------------------
    always_ff @(posedge sysclk) begin
        if (reset)
            reg_rdata <= '0;
        else
            reg_rdata <= rdata_sel;     // data for last cycle's reg_raddr
    end

endmodule

// File: verilog/board_regs.sv
/* main space channel 0 registers (status, version, watchdog
   period, IP address) and the watchdog timer */
`timescale 1ns/1ps
`include "board_bus_params.svh"

module board_regs (
    input  logic                     sysclk,
    input  logic                     reset,
    input  logic                     reg_wen,
    input  logic                     wdog_clear,       // external timeout clear
    input  logic [3:0]               board_id,         // rotary switch
    input  board_bus_pkg::reg_addr_t reg_raddr,
    input  board_bus_pkg::reg_addr_t reg_waddr,
    input  board_bus_pkg::reg_data_t reg_wdata,
    input  board_bus_pkg::reg_data_t reg_rdata_ext,
    output board_bus_pkg::reg_data_t board_rdata,
    output logic                     wdog_timeout,
    output logic                     wdog_period_led
);
    import board_bus_pkg::*;

    localparam int TICK_W = $clog2(`WDOG_TICK);

    logic [15:0]       wdog_period;    // zero disables the watchdog
    reg_data_t         ip_address;
    reg_data_t         status_word;
    logic              status_wen;
    logic              wdog_wen;
    logic              ip_wen;
    logic              wdog_restart;
    logic              tick_last;
    logic [TICK_W-1:0] tick_cnt;       // prescaler
    logic [15:0]       unit_cnt;       // elapsed period units

    // ----------------------------------------------------------
    // write decode, full address match in channel 0
    // ----------------------------------------------------------
    assign status_wen = reg_wen && (reg_waddr == {`ADDR_MAIN, 8'h00, `REG_STATUS});
    assign wdog_wen   = reg_wen && (reg_waddr == {`ADDR_MAIN, 8'h00, `REG_WDOG});
    assign ip_wen     = reg_wen && (reg_waddr == {`ADDR_MAIN, 8'h00, `REG_IPADDR});

    always_ff @(posedge sysclk) begin
        if (reset) begin
            wdog_period     <= '0;
            wdog_period_led <= 1'b0;
            ip_address      <= '1;     // unassigned address
        end else begin
            if (status_wen)
                wdog_period_led <= reg_wdata[`STATUS_LED_BIT];
            if (wdog_wen)
                wdog_period <= reg_wdata[15:0];
            if (ip_wen)
                ip_address <= reg_wdata;
        end
    end

    // ----------------------------------------------------------
    // watchdog
    // ----------------------------------------------------------
    assign wdog_restart = reg_wen | wdog_clear | (wdog_period == 16'd0); // any bus write kicks
    assign tick_last    = (tick_cnt == TICK_W'(`WDOG_TICK - 1));

    always_ff @(posedge sysclk) begin
        if (reset || wdog_restart) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (unit_cnt != wdog_period) begin    // hold once expired
            tick_cnt <= tick_last ? '0 : tick_cnt + 1'b1;
            if (tick_last)
                unit_cnt <= unit_cnt + 16'd1;
        end
    end

    always_ff @(posedge sysclk) begin
        if (reset)
            wdog_timeout <= 1'b0;
        else if (wdog_clear || (status_wen && reg_wdata[`STATUS_WDOG_CLR_BIT]))
            wdog_timeout <= 1'b0;
        else if ((wdog_period != 16'd0) && (unit_cnt == wdog_period))
            wdog_timeout <= 1'b1;   // sticky until cleared
    end

    // ----------------------------------------------------------
    // read mux, indexed by reg_raddr[3:0]
    // ----------------------------------------------------------
    always_comb begin
        status_word                   = '0;
        status_word[27:24]            = board_id;
        status_word[`STATUS_LED_BIT]  = wdog_period_led;
        status_word[0]                = wdog_timeout;
    end

    always_comb begin
        case (reg_raddr[3:0])
            `REG_STATUS:  board_rdata = status_word;
            `REG_WDOG:    board_rdata = {16'd0, wdog_period};
            `REG_VERSION: board_rdata = `FW_VERSION;
            `REG_IPADDR:  board_rdata = ip_address;
            default:      board_rdata = reg_rdata_ext;   // board-specific registers
        endcase
    end

endmodule

// File: verilog/hub_regs.sv
/* hub quadlet memory, bus written and combinationally read */
`timescale 1ns/1ps
`include "board_bus_params.svh"

module hub_regs (
    input  logic                     sysclk,
    input  logic                     reg_wen,
    input  board_bus_pkg::reg_addr_t reg_raddr,
    input  board_bus_pkg::reg_addr_t reg_waddr,
    input  board_bus_pkg::reg_data_t reg_wdata,
    output board_bus_pkg::reg_data_t hub_rdata
);
    import board_bus_pkg::*;

    localparam int IDX_W = $clog2(`HUB_QUADS);

    reg_data_t  hub_mem [`HUB_QUADS];   // one quadlet per index
    logic       hub_wen;

    // ----------------------------------------------------------
    // write port
    // ----------------------------------------------------------
    assign hub_wen = reg_wen && (reg_waddr[15:12] == `ADDR_HUB);

    always_ff @(posedge sysclk) begin
        if (hub_wen)
            hub_mem[reg_waddr[IDX_W-1:0]] <= reg_wdata;    // low bits index, rest ignored
    end

    // read port, router registers the result
    assign hub_rdata = hub_mem[reg_raddr[IDX_W-1:0]];

endmodule

// File: verilog/board_bus_top.sv
/* register bus top: write arbiter, read router, board
   registers and hub memory */
`timescale 1ns/1ps

module board_bus_top (
    input  logic                        sysclk,
    input  logic                        reset,
    input  logic [3:0]                  board_id,
    // block writer
    input  logic                        bw_write_en,
    input  logic                        bw_reg_wen,
    input  logic                        bw_blk_wen,
    input  logic                        bw_blk_wstart,
    input  board_bus_pkg::bw_addr_t     bw_reg_waddr,
    input  board_bus_pkg::reg_data_t    bw_reg_wdata,
    // Ethernet
    input  logic                        eth_write_en,
    input  logic                        eth_reg_wen,
    input  logic                        eth_blk_wen,
    input  logic                        eth_blk_wstart,
    input  board_bus_pkg::reg_addr_t    eth_reg_waddr,
    input  board_bus_pkg::reg_data_t    eth_reg_wdata,
    input  logic                        eth_read_en,
    input  board_bus_pkg::reg_addr_t    eth_reg_raddr,
    input  logic                        eth_rt_wen,
    input  board_bus_pkg::rt_addr_t     eth_rt_waddr,
    input  board_bus_pkg::reg_data_t    eth_rt_wdata,
    input  logic                        eth_sample_start,
    input  logic                        eth_sample_read,
    input  board_bus_pkg::sample_addr_t eth_sample_raddr,
    // FireWire
    input  logic                        fw_reg_wen,
    input  logic                        fw_blk_wen,
    input  logic                        fw_blk_wstart,
    input  board_bus_pkg::reg_addr_t    fw_reg_waddr,
    input  board_bus_pkg::reg_data_t    fw_reg_wdata,
    input  board_bus_pkg::reg_addr_t    fw_reg_raddr,
    input  logic                        fw_rt_wen,
    input  board_bus_pkg::rt_addr_t     fw_rt_waddr,
    input  board_bus_pkg::reg_data_t    fw_rt_wdata,
    input  logic                        fw_sample_start,
    input  logic                        fw_sample_read,
    input  board_bus_pkg::sample_addr_t fw_sample_raddr,
    // sampler, external board, watchdog
    input  logic                        sample_busy,
    input  board_bus_pkg::chan_t        sample_chan,
    input  board_bus_pkg::reg_data_t    reg_rdata_ext,
    input  logic                        wdog_clear,
    // shared bus
    output logic                        reg_wen,
    output logic                        blk_wen,
    output logic                        blk_wstart,
    output board_bus_pkg::reg_addr_t    reg_waddr,
    output board_bus_pkg::reg_data_t    reg_wdata,
    output logic                        rt_wen,
    output board_bus_pkg::rt_addr_t     rt_waddr,
    output board_bus_pkg::reg_data_t    rt_wdata,
    output logic                        sample_start,
    output logic                        sample_read,
    output board_bus_pkg::sample_addr_t sample_raddr,
    output board_bus_pkg::reg_addr_t    reg_raddr,
    output board_bus_pkg::reg_data_t    reg_rdata,
    output logic                        wdog_timeout,
    output logic                        wdog_period_led
);
    import board_bus_pkg::*;

    reg_data_t hub_rdata;       // hub space read data
    reg_data_t board_rdata;     // channel 0 read data

    // ----------------------------------------------------------
    // bus sharing
    // ----------------------------------------------------------
    write_bus_arbiter write_bus_arbiter_inst (.*);

    read_data_router read_data_router_inst (.*);

    // ----------------------------------------------------------
    // register targets on the shared bus
    // ----------------------------------------------------------
    board_regs board_regs_inst (
        .sysclk, .reset, .reg_wen, .wdog_clear, .board_id,
        .reg_raddr, .reg_waddr, .reg_wdata, .reg_rdata_ext,
        .board_rdata, .wdog_timeout, .wdog_period_led
    );

    hub_regs hub_regs_inst (
        .sysclk, .reg_wen, .reg_raddr, .reg_waddr, .reg_wdata, .hub_rdata
    );

endmodule

// File: bench/tb_board_bus.sv
/* register bus testbench: LCG random stimulus, shadow model of board
   registers, hub memory and watchdog, compare tasks per result type */
`timescale 1ns/1ps
`include "board_bus_params.svh"

module tb_board_bus;
    import board_bus_pkg::*;

    localparam int HUB_IDX_W = $clog2(`HUB_QUADS);

    logic         sysclk = 1'b0;
    logic         reset;
    logic [3:0]   board_id;
    logic         bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart;
    logic         eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart, eth_read_en;
    logic         fw_reg_wen, fw_blk_wen, fw_blk_wstart;
    logic         eth_rt_wen, fw_rt_wen, wdog_clear, sample_busy;
    logic         eth_sample_start, fw_sample_start, eth_sample_read, fw_sample_read;
    bw_addr_t     bw_reg_waddr;
    reg_addr_t    eth_reg_waddr, fw_reg_waddr, eth_reg_raddr, fw_reg_raddr;
    reg_data_t    bw_reg_wdata, eth_reg_wdata, fw_reg_wdata;
    reg_data_t    eth_rt_wdata, fw_rt_wdata, reg_rdata_ext;
    rt_addr_t     eth_rt_waddr, fw_rt_waddr;
    sample_addr_t eth_sample_raddr, fw_sample_raddr;
    chan_t        sample_chan;
    // DUT outputs
    logic         reg_wen, blk_wen, blk_wstart, rt_wen, sample_start, sample_read;
    logic         wdog_timeout, wdog_period_led;
    reg_addr_t    reg_waddr, reg_raddr;
    reg_data_t    reg_wdata, rt_wdata, reg_rdata;
    rt_addr_t     rt_waddr;
    sample_addr_t sample_raddr;
    // expected values and shadow state
    logic         exp_wen, exp_blk_wen, exp_blk_wstart, exp_rt_wen;
    logic         exp_sample_start, exp_sample_read;
    reg_addr_t    exp_waddr, exp_raddr;
    reg_data_t    exp_wdata, exp_rt_wdata;
    rt_addr_t     exp_rt_waddr;
    sample_addr_t exp_sample_raddr;
    reg_data_t    m_hub [`HUB_QUADS];
    reg_data_t    m_ip, m_rdata;
    logic [15:0]  m_period;
    logic         m_led, m_timeout;
    logic [31:0]  m_wdog_cnt;           // clocks since last restart, capped
    logic [31:0]  seed = 32'h1298;
    int           checks = 0;
    int           errors = 0;

    board_bus_top board_bus_top_inst (.*);

    always #4 sysclk = ~sysclk;         // 8 ns period

    // ----------------------------------------------------------
    // reference model
    // ----------------------------------------------------------
    assign exp_wen   = bw_write_en ? bw_reg_wen : eth_write_en ? eth_reg_wen : fw_reg_wen;
    assign exp_blk_wen    = bw_write_en ? bw_blk_wen : eth_write_en ? eth_blk_wen : fw_blk_wen;
    assign exp_blk_wstart = bw_write_en ? bw_blk_wstart
                          : eth_write_en ? eth_blk_wstart : fw_blk_wstart;
    assign exp_waddr = bw_write_en ? {8'h00, bw_reg_waddr}          // bw sits in low page
                     : eth_write_en ? eth_reg_waddr : fw_reg_waddr;
    assign exp_wdata = bw_write_en ? bw_reg_wdata : eth_write_en ? eth_reg_wdata : fw_reg_wdata;
    assign exp_rt_wen       = eth_rt_wen | fw_rt_wen;
    assign exp_rt_waddr     = eth_rt_wen ? eth_rt_waddr : fw_rt_waddr;
    assign exp_rt_wdata     = eth_rt_wen ? eth_rt_wdata : fw_rt_wdata;
    assign exp_sample_start = (eth_sample_start | fw_sample_start) & ~sample_busy;
    assign exp_sample_read  = eth_sample_read | fw_sample_read;
    assign exp_sample_raddr = eth_sample_read ? eth_sample_raddr : fw_sample_raddr;
    assign exp_raddr = sample_busy ? {`ADDR_MAIN, 4'h0, sample_chan, 4'h0}
                     : eth_read_en ? eth_reg_raddr : fw_reg_raddr;

    function automatic reg_addr_t main_reg(input logic [3:0] idx);
        return {`ADDR_MAIN, 8'h00, idx};
    endfunction

    function automatic reg_data_t model_read(input reg_addr_t a);
        reg_data_t st;
        st                  = '0;
        st[27:24]           = board_id;
        st[`STATUS_LED_BIT] = m_led;
        st[0]               = m_timeout;
        if (a[15:12] == `ADDR_HUB)
            return m_hub[a[HUB_IDX_W-1:0]];
        if (a[15:12] != `ADDR_MAIN || a[7:4] != 4'h0)
            return reg_rdata_ext;       // channel data, other spaces
        case (a[3:0])
            `REG_STATUS:  return st;
            `REG_WDOG:    return {16'h0, m_period};
            `REG_VERSION: return `FW_VERSION;
            `REG_IPADDR:  return m_ip;
            default:      return reg_rdata_ext;
        endcase
    endfunction

    always @(posedge sysclk) begin
        if (reset) begin
            m_rdata    <= '0;
            m_period   <= '0;
            m_led      <= 1'b0;
            m_ip       <= '1;
            m_timeout  <= 1'b0;
            m_wdog_cnt <= '0;
        end else begin
            m_rdata <= model_read(exp_raddr);
            if (exp_wen && exp_waddr[15:12] == `ADDR_HUB)
                m_hub[exp_waddr[HUB_IDX_W-1:0]] <= exp_wdata;
            if (exp_wen && exp_waddr == main_reg(`REG_STATUS))
                m_led <= exp_wdata[`STATUS_LED_BIT];
            if (exp_wen && exp_waddr == main_reg(`REG_WDOG))
                m_period <= exp_wdata[15:0];
            if (exp_wen && exp_waddr == main_reg(`REG_IPADDR))
                m_ip <= exp_wdata;
            if (exp_wen || wdog_clear || m_period == 16'd0)  // any write kicks the dog
                m_wdog_cnt <= '0;
            else if (m_wdog_cnt < m_period * `WDOG_TICK)
                m_wdog_cnt <= m_wdog_cnt + 1;
            if (wdog_clear || (exp_wen && exp_waddr == main_reg(`REG_STATUS)
                               && exp_wdata[`STATUS_WDOG_CLR_BIT]))
                m_timeout <= 1'b0;
            else if (m_period != 16'd0 && m_wdog_cnt == m_period * `WDOG_TICK)
                m_timeout <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {seed[15:0], seed[31:16]};   // high half has the better bits
    endfunction

    function automatic reg_addr_t rand_addr();
        logic [31:0] r;
        r = next_random();
        // mostly main or hub space, channel 0 half the time
        return {r[31] ? r[15:12] : {3'b000, r[14]}, 4'h0, r[30] ? r[7:4] : 4'h0, r[3:0]};
    endfunction

    task automatic randomize_inputs();
        logic [31:0] r;
        logic [31:0] s;
        r = next_random();
        s = next_random();
        {bw_write_en, bw_reg_wen, bw_blk_wen, bw_blk_wstart,
         eth_write_en, eth_reg_wen, eth_blk_wen, eth_blk_wstart} <= r[7:0];
        {fw_reg_wen, fw_blk_wen, fw_blk_wstart, eth_rt_wen, fw_rt_wen} <= r[12:8];
        {eth_sample_start, fw_sample_start, sample_busy,
         eth_sample_read, fw_sample_read, eth_read_en} <= r[18:13];
        wdog_clear       <= (r[23:19] == 5'd0);     // rare
        eth_rt_waddr     <= r[27:24];
        fw_rt_waddr      <= r[31:28];
        eth_sample_raddr <= s[5:0];
        fw_sample_raddr  <= s[11:6];
        sample_chan      <= s[15:12];
        board_id         <= s[19:16];
        bw_reg_waddr     <= s[27:20];
        bw_reg_wdata     <= next_random();
        eth_reg_waddr    <= rand_addr();
        eth_reg_wdata    <= next_random();
        fw_reg_waddr     <= rand_addr();
        fw_reg_wdata     <= next_random();
        eth_reg_raddr    <= rand_addr();
        fw_reg_raddr     <= rand_addr();
        eth_rt_wdata     <= next_random();
        fw_rt_wdata      <= next_random();
        reg_rdata_ext    <= next_random();
    endtask

    // fw owns the bus but does not strobe
    task automatic go_idle();
        {bw_write_en, eth_write_en, fw_reg_wen, fw_blk_wen, fw_blk_wstart,
         eth_rt_wen, fw_rt_wen, eth_sample_start, fw_sample_start, sample_busy,
         eth_sample_read, fw_sample_read, eth_read_en, wdog_clear} <= '0;
    endtask

    task automatic bus_write(input reg_addr_t addr, input reg_data_t data);
        @(posedge sysclk);
        fw_reg_wen   <= 1'b1;
        fw_reg_waddr <= addr;
        fw_reg_wdata <= data;
        @(posedge sysclk);
        fw_reg_wen   <= 1'b0;
    endtask

    task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
        @(posedge sysclk);
        fw_reg_raddr <= addr;
        @(posedge sysclk);              // one clock of read latency
        @(negedge sysclk);
        data = reg_rdata;
    endtask

    task automatic pulse_clear();
        @(posedge sysclk);
        wdog_clear <= 1'b1;
        @(posedge sysclk);
        wdog_clear <= 1'b0;
    endtask

    // ----------------------------------------------------------
    // checks
    // ----------------------------------------------------------
    task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic wait_wdog_flag(input int min_cycles, input int max_cycles);
        int n;
        n = 0;
        do begin
            @(negedge sysclk);
            n++;
        end while (!wdog_timeout && n < max_cycles);
        checks++;
        if (!wdog_timeout) begin
            errors++;
            $display("watchdog flag not set within %0d clocks", max_cycles);
        end else if (n < min_cycles) begin
            errors++;
            $display("watchdog flag set after %0d clocks, earlier than %0d", n, min_cycles);
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start)
            $display("%s: ok", name);
        else
            $display("%s: FAILED with %0d errors", name, errors - err_start);
    endtask

    // ----------------------------------------------------------
    // test sequence
    // ----------------------------------------------------------
    initial begin : main
        int          start;
        int          p;
        logic [31:0] r;
        reg_addr_t   a;
        reg_data_t   d;
        reg_data_t   q;
        reset <= 1'b1;
        randomize_inputs();
        go_idle();
        repeat (8) @(posedge sysclk);
        reset <= 1'b0;
        for (int i = 0; i < `HUB_QUADS; i++) begin
            a = {`ADDR_HUB, 8'h00, 4'(i)};
            bus_write(a, {~a, a});      // fill covers every hub quadlet
        end

        start = errors;
        repeat (300) begin
            @(posedge sysclk);
            randomize_inputs();
            @(negedge sysclk);
            check_bit("reg_wen", reg_wen, exp_wen);
            check_bit("blk_wen", blk_wen, exp_blk_wen);
            check_bit("blk_wstart", blk_wstart, exp_blk_wstart);
            check_addr("reg_waddr", reg_waddr, exp_waddr);
            check_data("reg_wdata", reg_wdata, exp_wdata);
        end
        report_test("write arbitration", start);

        start = errors;
        repeat (300) begin
            @(posedge sysclk);
            randomize_inputs();
            @(negedge sysclk);
            check_bit("rt_wen", rt_wen, exp_rt_wen);
            check_addr("rt_waddr", {12'h0, rt_waddr}, {12'h0, exp_rt_waddr});
            check_data("rt_wdata", rt_wdata, exp_rt_wdata);
            check_bit("sample_start", sample_start, exp_sample_start);
            check_bit("sample_read", sample_read, exp_sample_read);
            check_addr("sample_raddr", {10'h0, sample_raddr}, {10'h0, exp_sample_raddr});
        end
        report_test("real-time and sample merging", start);

        start = errors;
        repeat (500) begin
            @(posedge sysclk);
            randomize_inputs();
            @(negedge sysclk);
            check_addr("reg_raddr", reg_raddr, exp_raddr);
            check_data("reg_rdata", reg_rdata, m_rdata);    // previous cycle's address
            check_bit("wdog_timeout", wdog_timeout, m_timeout);
            check_bit("wdog_period_led", wdog_period_led, m_led);
        end
        report_test("read address and steering", start);

        start = errors;
        @(posedge sysclk);
        go_idle();
        repeat (8) begin
            r = next_random();
            a = {`ADDR_HUB, 8'h00, r[3:0]};
            d = next_random();
            bus_write(a, d);
            bus_read(a, q);
            check_data("hub readback", q, d);
        end
        d = next_random();
        bus_write(main_reg(`REG_IPADDR), d);
        bus_read(main_reg(`REG_IPADDR), q);
        check_data("ip_address", q, d);
        r = next_random();
        d = {16'h0, r[31:16]};
        bus_write(main_reg(`REG_WDOG), d);
        bus_read(main_reg(`REG_WDOG), q);
        check_data("wdog_period", q, d);
        bus_write(main_reg(`REG_STATUS), 32'h0000_0100);
        bus_read(main_reg(`REG_STATUS), q);
        check_bit("status led bit", q[`STATUS_LED_BIT], 1'b1);
        check_bit("wdog_period_led", wdog_period_led, 1'b1);
        bus_write(main_reg(`REG_STATUS), 32'h0);
        board_id <= 4'ha;
        bus_read(main_reg(`REG_STATUS), q);
        check_bit("status led bit", q[`STATUS_LED_BIT], 1'b0);
        check_data("status board_id", {28'h0, q[27:24]}, 32'h0000_000a);
        bus_read(main_reg(`REG_VERSION), q);
        check_data("version", q, `FW_VERSION);
        report_test("register readback", start);

        start = errors;
        r = next_random();
        p = int'(r[2:0]) + 2;
        bus_write(main_reg(`REG_WDOG), reg_data_t'(p));
        pulse_clear();
        wait_wdog_flag(p * `WDOG_TICK, p * `WDOG_TICK + 16);
        pulse_clear();
        @(negedge sysclk);
        check_bit("wdog_timeout after wdog_clear", wdog_timeout, 1'b0);
        repeat (p * `WDOG_TICK - 2) @(negedge sysclk);
        bus_write({`ADDR_HUB, 12'h000}, 32'h0);             // kick before expiry
        wait_wdog_flag(p * `WDOG_TICK, p * `WDOG_TICK + 16);
        bus_write(main_reg(`REG_STATUS), 32'h0000_0200);
        @(negedge sysclk);
        check_bit("wdog_timeout after status clear", wdog_timeout, 1'b0);
        bus_write(main_reg(`REG_WDOG), 32'h0);
        report_test("watchdog", start);

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: flist.f
+incdir+verilog
verilog/board_bus_pkg.sv
verilog/write_bus_arbiter.sv
verilog/read_data_router.sv
verilog/board_regs.sv
verilog/hub_regs.sv
verilog/board_bus_top.sv
bench/tb_board_bus.sv

// File: Makefile
# Verilator build and run of the register bus testbench

SIM      := verilator
SIMFLAGS := --binary --timing --timescale 1ns/1ps -j 0
TOP      := tb_board_bus
FLIST    := flist.f
OBJDIR   := obj_dir
SIMBIN   := $(OBJDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FLIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIMBIN): $(SOURCES) $(FLIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(SIMBIN)
	./$(SIMBIN) | tee $(LOG)
	grep -qx "Test passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
